// File: flist.f
hw/lc3b_types.sv
hw/reorder_buffer_data.sv
hw/reorder_buffer.sv
hw/rob_commit.sv
hw/lc3b_regfile.sv
hw/rob_subsystem.sv
testbench/rob_assertions.sv
testbench/rob_tb.sv

// File: hw/lc3b_regfile.sv
`timescale 1ns/10ps

module lc3b_regfile (
	input logic clk,
	input logic rst_n,
	input lc3b_types::rob_commit_t commit_in,
	input lc3b_types::lc3b_reg arch_read_addr,
	output lc3b_types::lc3b_word arch_read_value
);
	import lc3b_types::*;

	lc3b_word regs [8];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (commit_in.valid) begin
			regs[commit_in.dest] <= commit_in.value;
		end
	end

	assign arch_read_value = regs[arch_read_addr];  // No bypass from the commit port

endmodule : lc3b_regfile

// File: hw/lc3b_types.sv
package lc3b_types;

	typedef logic [15:0] lc3b_word;  // Data and PC word
	typedef logic [2:0] lc3b_reg;    // Architectural register index
	typedef logic [2:0] lc3b_tag;    // ROB entry tag on the CDB

	// LC-3b opcode from bits [15:12] of the instruction
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// Result broadcast from an execute unit
	typedef struct packed {
		logic valid;
		lc3b_tag tag;
		lc3b_word data;
	} CDB;

	// Register write produced at retire
	typedef struct packed {
		logic valid;
		lc3b_reg dest;
		lc3b_word value;
	} rob_commit_t;

	typedef enum logic {idle, retire} commit_state_t;

	// Branches retire without touching the register file
	function automatic logic writes_register(lc3b_opcode op);
		return op != op_br;
	endfunction

endpackage : lc3b_types

// File: hw/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer #(
	parameter int data_width = 16,
	parameter int tag_width = 3
) (
	input logic clk,
	input logic rst_n,
	input logic WE,
	input logic RE,
	input logic flush,

	input lc3b_types::lc3b_opcode inst,
	input lc3b_types::lc3b_reg dest,
	input logic [data_width-1:0] value,
	input logic predict,
	input lc3b_types::lc3b_word orig_pc_in,
	input lc3b_types::CDB CDB_in,

	input logic [tag_width-1:0] sr1_read_addr,
	input logic [tag_width-1:0] sr2_read_addr,

	output logic [tag_width-1:0] w_addr_out,
	output logic [tag_width-1:0] r_addr_out,
	output logic valid_out,
	output lc3b_types::lc3b_opcode inst_out,
	output lc3b_types::lc3b_reg dest_out,
	output logic [data_width-1:0] value_out,
	output logic predict_out,
	output lc3b_types::lc3b_word orig_pc_out,
	output logic empty_out,
	output logic full_out,

	output logic [data_width-1:0] sr1_value_out,
	output logic sr1_valid_out,
	output logic [data_width-1:0] sr2_value_out,
	output logic sr2_valid_out
);
	import lc3b_types::*;

	lc3b_opcode inst_in;
	lc3b_reg dest_in;
	logic [data_width-1:0] value_in_fifo, value_in_addr;
	logic predict_in;
	logic ld_inst, ld_dest, ld_value, ld_valid, ld_predict, ld_orig_pc;
	logic [tag_width-1:0] addr_in;
	logic empty, full;
	logic [data_width-1:0] data_sr1_value_out, data_sr2_value_out;
	lc3b_opcode sr1_opcode, sr2_opcode;
	logic sr1_predict, sr2_predict;
	lc3b_word sr1_orig_pc_out, sr2_orig_pc_out;

	// Dispatch fields all load on WE
	assign ld_inst = WE;
	assign ld_dest = WE;
	assign ld_predict = WE;
	assign ld_orig_pc = WE;
	assign inst_in = inst;
	assign dest_in = dest;
	assign value_in_fifo = value;
	assign predict_in = predict;

	// CDB writeback
	assign ld_value = CDB_in.valid;
	assign ld_valid = CDB_in.valid;
	assign value_in_addr = data_width'(CDB_in.data);
	assign addr_in = tag_width'(CDB_in.tag);

	assign empty_out = empty;
	assign full_out = full;

	// Each port gives the link value of its own predicted JSR
	assign sr1_value_out = (sr1_opcode == op_jsr && sr1_predict) ?
		data_width'(sr1_orig_pc_out + 16'd2) : data_sr1_value_out;
	assign sr2_value_out = (sr2_opcode == op_jsr && sr2_predict) ?
		data_width'(sr2_orig_pc_out + 16'd2) : data_sr2_value_out;

	reorder_buffer_data #(
		.data_width(data_width),
		.tag_width(tag_width)
	) rob_data_i (.*);

endmodule : reorder_buffer

// File: hw/reorder_buffer_data.sv
`timescale 1ns/10ps

module reorder_buffer_data #(
	parameter int data_width = 16,
	parameter int tag_width = 3
) (
	input logic clk,
	input logic rst_n,
	input logic flush,

	input logic ld_inst,
	input logic ld_dest,
	input logic ld_value,
	input logic ld_valid,
	input logic ld_predict,
	input logic ld_orig_pc,
	input logic RE,

	input lc3b_types::lc3b_opcode inst_in,
	input lc3b_types::lc3b_reg dest_in,
	input logic [data_width-1:0] value_in_fifo,  // Initial value at dispatch
	input logic [data_width-1:0] value_in_addr,  // Result from the CDB
	input logic predict_in,
	input lc3b_types::lc3b_word orig_pc_in,
	input logic [tag_width-1:0] addr_in,

	input logic [tag_width-1:0] sr1_read_addr,
	input logic [tag_width-1:0] sr2_read_addr,

	output logic [tag_width-1:0] w_addr_out,
	output logic [tag_width-1:0] r_addr_out,

	output logic valid_out,
	output logic predict_out,
	output lc3b_types::lc3b_opcode inst_out,
	output lc3b_types::lc3b_reg dest_out,
	output logic [data_width-1:0] value_out,
	output lc3b_types::lc3b_word orig_pc_out,

	output logic empty,
	output logic full,

	output logic [data_width-1:0] data_sr1_value_out,
	output logic [data_width-1:0] data_sr2_value_out,
	output logic sr1_valid_out,
	output logic sr2_valid_out,
	output lc3b_types::lc3b_opcode sr1_opcode,
	output lc3b_types::lc3b_opcode sr2_opcode,
	output logic sr1_predict,
	output logic sr2_predict,
	output lc3b_types::lc3b_word sr1_orig_pc_out,
	output lc3b_types::lc3b_word sr2_orig_pc_out
);
	import lc3b_types::*;

	localparam int depth = 1 << tag_width;

	// Entry fields
	lc3b_opcode inst_arr [depth];
	lc3b_reg dest_arr [depth];
	logic [data_width-1:0] value_arr [depth];
	logic [depth-1:0] predict_vec;
	lc3b_word orig_pc_arr [depth];
	logic [depth-1:0] valid_vec;  // Result has arrived

	// Extra top bit tells full from empty
	logic [tag_width:0] head_ptr;
	logic [tag_width:0] tail_ptr;
	logic [tag_width-1:0] head_idx;
	logic [tag_width-1:0] tail_idx;
	logic push;
	logic pop;

	assign head_idx = head_ptr[tag_width-1:0];
	assign tail_idx = tail_ptr[tag_width-1:0];

	assign empty = (head_ptr == tail_ptr);
	assign full = (head_ptr[tag_width] != tail_ptr[tag_width]) && (head_idx == tail_idx);

	assign push = ld_inst & ~full;  // Dropped while full
	assign pop = RE & ~empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			valid_vec <= '0;
		end else if (flush) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			valid_vec <= '0;
		end else begin
			if (push) begin
				tail_ptr <= tail_ptr + 1'b1;
				valid_vec[tail_idx] <= 1'b0;  // Pending until its CDB beat
			end
			if (ld_valid)
				valid_vec[addr_in] <= 1'b1;
			if (pop)
				head_ptr <= head_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			inst_arr[tail_idx] <= inst_in;
			value_arr[tail_idx] <= value_in_fifo;
		end
		if (ld_dest && !full)
			dest_arr[tail_idx] <= dest_in;
		if (ld_predict && !full)
			predict_vec[tail_idx] <= predict_in;
		if (ld_orig_pc && !full)
			orig_pc_arr[tail_idx] <= orig_pc_in;
		// CDB result lands after any dispatch write
		if (ld_value)
			value_arr[addr_in] <= value_in_addr;
	end

	assign w_addr_out = tail_idx;
	assign r_addr_out = head_idx;

	// Head entry
	assign valid_out = valid_vec[head_idx] & ~empty;
	assign predict_out = predict_vec[head_idx];
	assign inst_out = inst_arr[head_idx];
	assign dest_out = dest_arr[head_idx];
	assign value_out = value_arr[head_idx];
	assign orig_pc_out = orig_pc_arr[head_idx];

	// Operand lookup by tag
	assign data_sr1_value_out = value_arr[sr1_read_addr];
	assign data_sr2_value_out = value_arr[sr2_read_addr];
	assign sr1_valid_out = valid_vec[sr1_read_addr];
	assign sr2_valid_out = valid_vec[sr2_read_addr];
	assign sr1_opcode = inst_arr[sr1_read_addr];
	assign sr2_opcode = inst_arr[sr2_read_addr];
	assign sr1_predict = predict_vec[sr1_read_addr];
	assign sr2_predict = predict_vec[sr2_read_addr];
	assign sr1_orig_pc_out = orig_pc_arr[sr1_read_addr];
	assign sr2_orig_pc_out = orig_pc_arr[sr2_read_addr];

endmodule : reorder_buffer_data

// File: hw/rob_commit.sv
`timescale 1ns/10ps

module rob_commit (
	input logic clk,
	input logic rst_n,
	input logic valid_out,
	input lc3b_types::lc3b_opcode inst_out,
	input lc3b_types::lc3b_reg dest_out,
	input lc3b_types::lc3b_word value_out,
	input logic empty_out,
	output logic RE,
	output lc3b_types::rob_commit_t commit_out
);
	import lc3b_types::*;

	commit_state_t state, next_state;
	logic head_ready;

	assign head_ready = valid_out & ~empty_out;

	always_comb begin
		next_state = state;
		case (state)
			idle: if (head_ready) next_state = retire;
			retire: if (!head_ready) next_state = idle;  // Back-to-back retires stay here
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= idle;
		else
			state <= next_state;
	end

	// Retire decision is combinational from the head
	assign RE = head_ready;

	always_comb begin
		commit_out.valid = head_ready & writes_register(inst_out);
		commit_out.dest = dest_out;
		commit_out.value = value_out;
	end

endmodule : rob_commit

// File: hw/rob_subsystem.sv
`timescale 1ns/10ps

module rob_subsystem #(
	parameter int data_width = 16,
	parameter int tag_width = 3
) (
	input logic clk,
	input logic rst_n,

	input logic WE,
	input lc3b_types::lc3b_opcode inst,
	input lc3b_types::lc3b_reg dest,
	input logic [data_width-1:0] value,
	input logic predict,
	input lc3b_types::lc3b_word orig_pc_in,
	input lc3b_types::CDB cdb_in,
	input logic flush,

	input logic [tag_width-1:0] sr1_read_addr,
	input logic [tag_width-1:0] sr2_read_addr,

	output logic [tag_width-1:0] w_addr_out,
	output logic full_out,
	output logic empty_out,
	output logic [data_width-1:0] sr1_value_out,
	output logic sr1_valid_out,
	output logic [data_width-1:0] sr2_value_out,
	output logic sr2_valid_out,
	output lc3b_types::rob_commit_t commit_out,

	input lc3b_types::lc3b_reg arch_read_addr,
	output lc3b_types::lc3b_word arch_read_value
);
	import lc3b_types::*;

	// Head of the buffer toward commit
	logic head_valid;
	lc3b_opcode head_inst;
	lc3b_reg head_dest;
	logic [data_width-1:0] head_value;
	logic re;

	reorder_buffer #(
		.data_width(data_width),
		.tag_width(tag_width)
	) reorder_buffer_i (
		.clk(clk),
		.rst_n(rst_n),
		.WE(WE),
		.RE(re),
		.flush(flush),
		.inst(inst),
		.dest(dest),
		.value(value),
		.predict(predict),
		.orig_pc_in(orig_pc_in),
		.CDB_in(cdb_in),
		.sr1_read_addr(sr1_read_addr),
		.sr2_read_addr(sr2_read_addr),
		.w_addr_out(w_addr_out),
		.r_addr_out(),
		.valid_out(head_valid),
		.inst_out(head_inst),
		.dest_out(head_dest),
		.value_out(head_value),
		.predict_out(),
		.orig_pc_out(),
		.empty_out(empty_out),
		.full_out(full_out),
		.sr1_value_out(sr1_value_out),
		.sr1_valid_out(sr1_valid_out),
		.sr2_value_out(sr2_value_out),
		.sr2_valid_out(sr2_valid_out)
	);

	rob_commit rob_commit_i (
		.clk(clk),
		.rst_n(rst_n),
		.valid_out(head_valid),
		.inst_out(head_inst),
		.dest_out(head_dest),
		.value_out(lc3b_word'(head_value)),
		.empty_out(empty_out),
		.RE(re),
		.commit_out(commit_out)
	);

	lc3b_regfile lc3b_regfile_i (
		.clk(clk),
		.rst_n(rst_n),
		.commit_in(commit_out),
		.arch_read_addr(arch_read_addr),
		.arch_read_value(arch_read_value)
	);

endmodule : rob_subsystem

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the ROB testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module rob_tb -o rob_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rob_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" "$log"; then
	exit 0
fi
exit 1

// File: testbench/rob_assertions.sv
`timescale 1ns/10ps

module rob_assertions #(
	parameter int tag_width = 3
) (
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic full,
	input logic empty,
	input logic [tag_width:0] head_ptr,
	input logic [tag_width:0] tail_ptr
);

	full_and_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(full && empty))
		else $error("full and empty are both high");

	// Flush empties the buffer in one edge
	flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> (head_ptr == '0 && tail_ptr == '0))
		else $error("pointers not cleared after flush");

endmodule : rob_assertions

bind reorder_buffer_data rob_assertions #(
	.tag_width(tag_width)
) rob_assertions_i (
	.clk(clk),
	.rst_n(rst_n),
	.flush(flush),
	.full(full),
	.empty(empty),
	.head_ptr(head_ptr),
	.tail_ptr(tail_ptr)
);

// File: testbench/rob_stimulus.txt
# D op dest value predict pc | C tag data | F | N | E dest value | A reg value
# L tag1 tag2 val1 ok1 val2 ok2 | S full empty waddr | T name | fields in hex
D 1 1 0000 0 3000
D 5 2 0000 0 3002
D 9 3 0000 0 3004
C 2 00c3
C 1 00b2
N
C 0 00a1
E 1 00a1
E 2 00b2
E 3 00c3
A 1 00a1
A 2 00b2
A 3 00c3
T in_order
D 1 4 1111 0 3010
D 1 5 2222 0 3012
L 4 4 2222 0 2222 0
C 4 5555
L 3 4 1111 0 5555 1
L 4 3 5555 1 1111 0
C 3 7777
E 4 7777
E 5 5555
T lookup
# jsr is opcode 4, the first one predicted
D 4 7 0abc 1 4000
D 4 7 0abc 0 4000
L 5 6 4002 0 0abc 0
L 6 5 0abc 0 4002 0
C 5 1234
E 7 1234
C 6 5678
E 7 5678
T jsr_link
D 1 1 0000 0 5000
D 1 2 0000 0 5002
D 1 3 0000 0 5004
D 1 4 0000 0 5006
D 1 5 0000 0 5008
D 1 6 0000 0 500a
D 1 7 0000 0 500c
D 1 1 0000 0 500e
S 1 0 7
D 1 2 0000 0 5010
S 1 0 7
T full
F
S 0 1 0
C 0 9999
N
N
A 1 00a1
A 2 00b2
A 4 7777
T flush
D 0 1 0000 0 6000
D 1 3 0000 0 6002
C 1 0f0f
C 0 0000
N
E 3 0f0f
A 1 00a1
A 3 0f0f
T branch

// File: testbench/rob_tb.sv
`timescale 1ns/10ps

module rob_tb;
	import lc3b_types::*;

	localparam int data_width = 16;
	localparam int tag_width = 3;
	localparam string stim_file = "testbench/rob_stimulus.txt";

	logic clk;
	logic rst_n;
	logic WE;
	lc3b_opcode inst;
	lc3b_reg dest;
	logic [data_width-1:0] value;
	logic predict;
	lc3b_word orig_pc_in;
	CDB cdb_in;
	logic flush;
	logic [tag_width-1:0] sr1_read_addr;
	logic [tag_width-1:0] sr2_read_addr;
	logic [tag_width-1:0] w_addr_out;
	logic full_out;
	logic empty_out;
	logic [data_width-1:0] sr1_value_out;
	logic sr1_valid_out;
	logic [data_width-1:0] sr2_value_out;
	logic sr2_valid_out;
	rob_commit_t commit_out;
	lc3b_reg arch_read_addr;
	lc3b_word arch_read_value;

	int checks = 0;
	int errors = 0;
	int tests = 0;
	int test_first_error = 0;
	int cycle_count = 0;
	int cycle_limit = 0;  // Zero until the stimulus is counted

	rob_subsystem #(
		.data_width(data_width),
		.tag_width(tag_width)
	) rob_subsystem_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: commits did not finish");
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic check_word(input lc3b_word got, input lc3b_word exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_tag(input logic [tag_width-1:0] got, input logic [tag_width-1:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_commit(input rob_commit_t got, input rob_commit_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Advance one edge and drop the strobes back to idle
	task automatic next_cycle();
		@(posedge clk);
		WE <= 1'b0;
		flush <= 1'b0;
		cdb_in.valid <= 1'b0;
	endtask

	task automatic dispatch(input lc3b_opcode op, input lc3b_reg d, input lc3b_word v,
			input logic p, input lc3b_word pc);
		next_cycle();
		WE <= 1'b1;
		inst <= op;
		dest <= d;
		value <= v;
		predict <= p;
		orig_pc_in <= pc;
	endtask

	task automatic broadcast(input logic [tag_width-1:0] t, input lc3b_word d);
		next_cycle();
		cdb_in.valid <= 1'b1;
		cdb_in.tag <= t;
		cdb_in.data <= d;
	endtask

	task automatic flush_buffer();
		next_cycle();
		flush <= 1'b1;
	endtask

	task automatic lookup(input logic [tag_width-1:0] t1, input logic [tag_width-1:0] t2,
			input lc3b_word v1, input logic ok1, input lc3b_word v2, input logic ok2);
		next_cycle();
		sr1_read_addr <= t1;
		sr2_read_addr <= t2;
		@(negedge clk);
		check_word(sr1_value_out, v1, "sr1 value");
		check_flag(sr1_valid_out, ok1, "sr1 valid");
		check_word(sr2_value_out, v2, "sr2 value");
		check_flag(sr2_valid_out, ok2, "sr2 valid");
	endtask

	// Waits until the head commits
	task automatic expect_commit(input lc3b_reg d, input lc3b_word v);
		rob_commit_t exp;
		logic late;
		exp.valid = 1'b1;
		exp.dest = d;
		exp.value = v;
		late = 1'b0;
		next_cycle();
		@(negedge clk);
		while (!commit_out.valid) begin
			late = 1'b1;
			next_cycle();
			@(negedge clk);
		end
		check_flag(late, 1'b0, "commit delayed");
		check_commit(commit_out, exp, "commit");
	endtask

	task automatic no_commit();
		next_cycle();
		@(negedge clk);
		check_flag(commit_out.valid, 1'b0, "commit valid");
	endtask

	task automatic arch_read(input lc3b_reg r, input lc3b_word v);
		next_cycle();
		arch_read_addr <= r;
		@(negedge clk);
		check_word(arch_read_value, v, "arch register");
	endtask

	task automatic buffer_status(input logic f, input logic e, input logic [tag_width-1:0] t);
		next_cycle();
		@(negedge clk);
		check_flag(full_out, f, "full_out");
		check_flag(empty_out, e, "empty_out");
		check_tag(w_addr_out, t, "w_addr_out");
	endtask

	task automatic end_test(input logic [8*16-1:0] name);
		tests++;
		if (errors == test_first_error)
			$display("test %0s: pass", name);
		else
			$display("test %0s: fail with %0d errors", name, errors - test_first_error);
		test_first_error = errors;
	endtask

	initial begin
		integer fd;
		integer code;
		integer n_lines;
		logic [7:0] cmd;
		logic [31:0] f0, f1, f2, f3, f4, f5;
		logic [8*128-1:0] line_buf;
		logic [8*16-1:0] test_name;

		rst_n <= 1'b0;
		WE <= 1'b0;
		inst <= op_br;
		dest <= '0;
		value <= '0;
		predict <= 1'b0;
		orig_pc_in <= '0;
		cdb_in <= '0;
		flush <= 1'b0;
		sr1_read_addr <= '0;
		sr2_read_addr <= '0;
		arch_read_addr <= '0;

		fd = $fopen(stim_file, "r");
		if (fd == 0) begin
			$display("stimulus file %s could not be opened", stim_file);
			$display("ERRORS FOUND");
			$finish;
		end else begin
			n_lines = 0;
			while (!$feof(fd)) begin
				code = $fgets(line_buf, fd);
				if (code > 0)
					n_lines++;
			end
			$fclose(fd);
			cycle_limit = 20 * n_lines;
			fd = $fopen(stim_file, "r");

			repeat (4) @(posedge clk);
			rst_n <= 1'b1;

			while ($fscanf(fd, " %c", cmd) == 1) begin
				case (cmd)
					"#": code = $fgets(line_buf, fd);  // Rest of a comment line
					"D": begin
						code = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
						dispatch(lc3b_opcode'(f0[3:0]), f1[2:0], f2[15:0], f3[0], f4[15:0]);
					end
					"C": begin
						code = $fscanf(fd, "%h %h", f0, f1);
						broadcast(f0[tag_width-1:0], f1[15:0]);
					end
					"F": flush_buffer();
					"L": begin
						code = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
						lookup(f0[tag_width-1:0], f1[tag_width-1:0], f2[15:0], f3[0],
							f4[15:0], f5[0]);
					end
					"E": begin
						code = $fscanf(fd, "%h %h", f0, f1);
						expect_commit(f0[2:0], f1[15:0]);
					end
					"N": no_commit();
					"A": begin
						code = $fscanf(fd, "%h %h", f0, f1);
						arch_read(f0[2:0], f1[15:0]);
					end
					"S": begin
						code = $fscanf(fd, "%h %h %h", f0, f1, f2);
						buffer_status(f0[0], f1[0], f2[tag_width-1:0]);
					end
					"T": begin
						code = $fscanf(fd, "%s", test_name);
						end_test(test_name);
					end
					default: begin
						errors++;
						$display("unknown stimulus command %c in %s", cmd, stim_file);
					end
				endcase
			end
			$fclose(fd);

			$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
			if (errors == 0)
				$display("NO ERRORS");
			else
				$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule : rob_tb
